/* common/gat_pkg.sv */
package gat_pkg;

  // Fixed point data, 8 fraction bits
  localparam int DATA_W      = 16;
  localparam int FRAC_BITS   = 8;
  localparam int LEAKY_SHIFT = 2;
  localparam int SCORE_W     = DATA_W + 1;

  localparam int FEAT_NUM    = 4;
  localparam int FEAT_IDX_W  = $clog2(FEAT_NUM);
  localparam int MAX_NODES   = 4;
  localparam int SLOT_W      = $clog2(MAX_NODES);
  localparam int NODE_CNT_W  = $clog2(MAX_NODES + 1);

  localparam int WH_DEPTH    = 64;
  localparam int WH_ADDR_W   = $clog2(WH_DEPTH);
  localparam int SG_DEPTH    = 16;
  localparam int SG_ADDR_W   = $clog2(SG_DEPTH);
  localparam int SG_CNT_W    = $clog2(SG_DEPTH + 1);

  localparam int FIFO_DEPTH  = 4;
  localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
  localparam int CREDIT_W    = $clog2(FIFO_DEPTH + 1);

  // Full precision product and dot product sum
  localparam int PROD_W      = 2 * DATA_W;
  localparam int SUM_W       = PROD_W + $clog2(FEAT_NUM);

  typedef logic signed [DATA_W-1:0]  data_t;
  typedef logic signed [SCORE_W-1:0] score_t;

  typedef data_t [FEAT_NUM-1:0] wh_row_t;

  typedef struct packed {
    logic [WH_ADDR_W-1:0]  first_row;
    logic [NODE_CNT_W-1:0] node_cnt;
  } sg_info_t;

  // Slots at or beyond node_cnt hold zero
  typedef struct packed {
    logic [SG_ADDR_W-1:0]   sg_idx;
    logic [NODE_CNT_W-1:0]  node_cnt;
    data_t [MAX_NODES-1:0]  coef;
  } coef_rec_t;

  typedef struct packed {
    logic [SG_ADDR_W-1:0]   sg_idx;
    logic [NODE_CNT_W-1:0]  node_cnt;
    score_t [MAX_NODES-1:0] score;
  } score_rec_t;

  // Arithmetic shift by the fraction bits, then wrap to one word
  function automatic data_t rescale(input logic signed [SUM_W-1:0] sum);
    return data_t'(sum >>> FRAC_BITS);
  endfunction

  function automatic data_t leaky_relu(input data_t x);
    return x[DATA_W-1] ? data_t'(x >>> LEAKY_SHIFT) : x;
  endfunction

endpackage

/* dmvm/attention_dot.sv */
`timescale 1ns/1ps

module attention_dot (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           a_we_i,
  input  logic [gat_pkg::FEAT_IDX_W-1:0] a_idx_i,
  input  gat_pkg::data_t                 a_data_i,
  input  logic                           row_vld_i,
  input  logic [gat_pkg::SLOT_W-1:0]     row_slot_i,
  input  logic                           row_last_i,
  input  logic [gat_pkg::NODE_CNT_W-1:0] row_cnt_i,
  input  logic [gat_pkg::SG_ADDR_W-1:0]  row_sg_i,
  input  gat_pkg::wh_row_t               wh_row_i,
  output logic                           push_o,
  output gat_pkg::coef_rec_t             rec_o
);
  import gat_pkg::*;

  typedef struct packed {
    logic                  vld;
    logic                  last;
    logic [SLOT_W-1:0]     slot;
    logic [NODE_CNT_W-1:0] cnt;
    logic [SG_ADDR_W-1:0]  sg;
  } tag_t;

  data_t                    a_q [FEAT_NUM];
  tag_t                     tag_in;
  tag_t                     s1_tag;
  tag_t                     s2_tag;
  tag_t                     s3_tag;
  logic signed [PROD_W-1:0] s1_prod [FEAT_NUM];
  logic signed [SUM_W-1:0]  sum_c;
  logic signed [SUM_W-1:0]  s2_sum;
  data_t                    s3_coef;
  coef_rec_t                acc_nxt;

  always_ff @(posedge clk) begin
    if (a_we_i) begin
      a_q[a_idx_i] <= a_data_i;
    end
  end

  assign tag_in = '{vld: row_vld_i, last: row_last_i, slot: row_slot_i,
                    cnt: row_cnt_i, sg: row_sg_i};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_tag <= '0;
      s2_tag <= '0;
      s3_tag <= '0;
    end else begin
      s1_tag <= tag_in;
      s2_tag <= s1_tag;
      s3_tag <= s2_tag;
    end
  end

  always_comb begin
    sum_c = '0;
    for (int i = 0; i < FEAT_NUM; i++) begin
      sum_c = sum_c + s1_prod[i];
    end
  end

  // Multiply, sum, rescale with LeakyReLU
  always_ff @(posedge clk) begin
    for (int i = 0; i < FEAT_NUM; i++) begin
      s1_prod[i] <= a_q[i] * $signed(wh_row_i[i]);
    end
    s2_sum  <= sum_c;
    s3_coef <= leaky_relu(rescale(s2_sum));
  end

  // Record starts from zero after each push
  always_comb begin
    acc_nxt = push_o ? '0 : rec_o;
    if (s3_tag.vld) begin
      acc_nxt.sg_idx              = s3_tag.sg;
      acc_nxt.node_cnt            = s3_tag.cnt;
      acc_nxt.coef[s3_tag.slot]   = s3_coef;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rec_o  <= '0;
      push_o <= 1'b0;
    end else begin
      rec_o  <= acc_nxt;
      push_o <= s3_tag.vld && s3_tag.last;
    end
  end

endmodule

/* dmvm/subgraph_fetch.sv */
`timescale 1ns/1ps

module subgraph_fetch (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start_i,
  input  logic [gat_pkg::SG_CNT_W-1:0]   num_sg_i,
  output logic [gat_pkg::SG_ADDR_W-1:0]  sg_addr_o,
  input  gat_pkg::sg_info_t              sg_data_i,
  output logic [gat_pkg::WH_ADDR_W-1:0]  wh_addr_o,
  input  logic                           credit_ret_i,
  output logic                           row_vld_o,
  output logic [gat_pkg::SLOT_W-1:0]     row_slot_o,
  output logic                           row_last_o,
  output logic [gat_pkg::NODE_CNT_W-1:0] row_cnt_o,
  output logic [gat_pkg::SG_ADDR_W-1:0]  row_sg_o,
  output logic                           done_o
);
  import gat_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_TBL, S_ROW, S_FIN} state_t;

  state_t              state;
  logic [SG_CNT_W-1:0] num_sg_q;
  logic [SG_CNT_W-1:0] sg_cnt;
  logic [SLOT_W-1:0]   node_idx;
  logic [CREDIT_W-1:0] credit;
  logic                sg_first;
  logic                sg_empty;
  logic                take;
  logic                issue;
  logic                last_row;
  logic                last_sg;

  assign sg_first = (node_idx == '0);
  assign sg_empty = (sg_data_i.node_cnt == '0);
  // A subgraph opens only with a spare FIFO slot
  assign take     = (state == S_ROW) && sg_first && !sg_empty && (credit != '0);
  assign issue    = take || ((state == S_ROW) && !sg_first);
  assign last_row = (NODE_CNT_W'(node_idx) + NODE_CNT_W'(1)) == sg_data_i.node_cnt;
  assign last_sg  = (sg_cnt + SG_CNT_W'(1)) == num_sg_q;

  assign sg_addr_o = sg_cnt[SG_ADDR_W-1:0];
  assign wh_addr_o = sg_data_i.first_row + WH_ADDR_W'(node_idx);
  assign done_o    = (state == S_FIN);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      num_sg_q <= '0;
      sg_cnt   <= '0;
      node_idx <= '0;
      credit   <= CREDIT_W'(FIFO_DEPTH);
    end else begin
      credit <= credit - CREDIT_W'(take) + CREDIT_W'(credit_ret_i);
      case (state)
        S_IDLE: begin
          if (start_i) begin
            num_sg_q <= num_sg_i;
            sg_cnt   <= '0;
            state    <= (num_sg_i == '0) ? S_FIN : S_TBL;
          end
        end
        // Table entry in flight
        S_TBL: state <= S_ROW;
        S_ROW: begin
          if (issue && !last_row) begin
            node_idx <= node_idx + 1'b1;
          end else if (issue || (sg_first && sg_empty)) begin
            node_idx <= '0;
            sg_cnt   <= sg_cnt + 1'b1;
            state    <= last_sg ? S_FIN : S_TBL;
          end
        end
        default: state <= S_FIN;
      endcase
    end
  end

  // Strobe lines up with the WH read data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_vld_o  <= 1'b0;
      row_last_o <= 1'b0;
    end else begin
      row_vld_o  <= issue;
      row_last_o <= issue && last_row;
    end
  end

  always_ff @(posedge clk) begin
    row_slot_o <= node_idx;
    row_cnt_o  <= sg_data_i.node_cnt;
    row_sg_o   <= sg_cnt[SG_ADDR_W-1:0];
  end

endmodule

/* hw/coef_fifo.sv */
`timescale 1ns/1ps

module coef_fifo (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               push_i,
  input  gat_pkg::coef_rec_t data_i,
  input  logic               pop_i,
  output gat_pkg::coef_rec_t data_o,
  output logic               empty_o
);
  import gat_pkg::*;

  coef_rec_t             mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [CREDIT_W-1:0]   count;

  assign data_o  = mem[rd_ptr];
  assign empty_o = (count == '0);

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Room is guaranteed by the credits upstream
      count <= count + CREDIT_W'(push_i) - CREDIT_W'(pop_i);
    end
  end

endmodule

/* hw/gat_bram.sv */
`timescale 1ns/1ps

module gat_bram #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  payload_t                 wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output payload_t                 rdata_o
);

  payload_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // One cycle read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_o <= '0;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

/* hw/gat_top.sv */
`timescale 1ns/1ps

module gat_top (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           wh_we_i,
  input  logic [gat_pkg::WH_ADDR_W-1:0]  wh_addr_i,
  input  gat_pkg::wh_row_t               wh_data_i,
  input  logic                           wh_load_done_i,

  input  logic                           sg_we_i,
  input  logic [gat_pkg::SG_ADDR_W-1:0]  sg_addr_i,
  input  gat_pkg::sg_info_t              sg_data_i,
  input  logic                           sg_load_done_i,

  input  logic                           a_we_i,
  input  logic [gat_pkg::FEAT_IDX_W-1:0] a_idx_i,
  input  gat_pkg::data_t                 a_data_i,
  input  logic                           a_load_done_i,

  input  logic [gat_pkg::SG_CNT_W-1:0]   num_sg_i,

  output logic                           score_valid_o,
  output gat_pkg::score_rec_t            score_o,
  output logic                           done_o
);
  import gat_pkg::*;

  logic                  start;
  logic [SG_ADDR_W-1:0]  sg_rd_addr;
  sg_info_t              sg_rd_data;
  logic [WH_ADDR_W-1:0]  wh_rd_addr;
  wh_row_t               wh_rd_data;
  logic                  row_vld;
  logic [SLOT_W-1:0]     row_slot;
  logic                  row_last;
  logic [NODE_CNT_W-1:0] row_cnt;
  logic [SG_ADDR_W-1:0]  row_sg;
  logic                  fetch_done;
  logic                  push;
  coef_rec_t             push_rec;
  logic                  pop;
  coef_rec_t             head_rec;
  logic                  fifo_empty;

  assign start = wh_load_done_i && sg_load_done_i && a_load_done_i;

  gat_bram #(
    .payload_t (wh_row_t),
    .DEPTH     (WH_DEPTH)
  ) u_wh_bram (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (wh_we_i),
    .waddr_i (wh_addr_i),
    .wdata_i (wh_data_i),
    .raddr_i (wh_rd_addr),
    .rdata_o (wh_rd_data)
  );

  gat_bram #(
    .payload_t (sg_info_t),
    .DEPTH     (SG_DEPTH)
  ) u_sg_bram (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (sg_we_i),
    .waddr_i (sg_addr_i),
    .wdata_i (sg_data_i),
    .raddr_i (sg_rd_addr),
    .rdata_o (sg_rd_data)
  );

  subgraph_fetch u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start),
    .num_sg_i     (num_sg_i),
    .sg_addr_o    (sg_rd_addr),
    .sg_data_i    (sg_rd_data),
    .wh_addr_o    (wh_rd_addr),
    .credit_ret_i (pop),
    .row_vld_o    (row_vld),
    .row_slot_o   (row_slot),
    .row_last_o   (row_last),
    .row_cnt_o    (row_cnt),
    .row_sg_o     (row_sg),
    .done_o       (fetch_done)
  );

  attention_dot u_dot (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_we_i     (a_we_i),
    .a_idx_i    (a_idx_i),
    .a_data_i   (a_data_i),
    .row_vld_i  (row_vld),
    .row_slot_i (row_slot),
    .row_last_i (row_last),
    .row_cnt_i  (row_cnt),
    .row_sg_i   (row_sg),
    .wh_row_i   (wh_rd_data),
    .push_o     (push),
    .rec_o      (push_rec)
  );

  coef_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (push),
    .data_i  (push_rec),
    .pop_i   (pop),
    .data_o  (head_rec),
    .empty_o (fifo_empty)
  );

  score_shift u_shift (
    .clk           (clk),
    .rst_n         (rst_n),
    .empty_i       (fifo_empty),
    .rec_i         (head_rec),
    .fetch_done_i  (fetch_done),
    .last_issued_i (row_last),
    .pop_o         (pop),
    .score_valid_o (score_valid_o),
    .score_o       (score_o),
    .done_o        (done_o)
  );

endmodule

/* hw/score_shift.sv */
`timescale 1ns/1ps

module score_shift (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                empty_i,
  input  gat_pkg::coef_rec_t  rec_i,
  input  logic                fetch_done_i,
  input  logic                last_issued_i,
  output logic                pop_o,
  output logic                score_valid_o,
  output gat_pkg::score_rec_t score_o,
  output logic                done_o
);
  import gat_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_SCAN, ST_EMIT} state_t;

  state_t              state;
  coef_rec_t           rec_q;
  data_t               max_q;
  logic [SLOT_W-1:0]   scan_idx;
  logic                scan_hit;
  logic [CREDIT_W-1:0] inflight;
  score_rec_t          score_c;

  assign pop_o    = (state == ST_IDLE) && !empty_i;
  assign scan_hit = (NODE_CNT_W'(scan_idx) < rec_q.node_cnt)
                    && ($signed(rec_q.coef[scan_idx]) > max_q);

  always_comb begin
    score_c.sg_idx   = rec_q.sg_idx;
    score_c.node_cnt = rec_q.node_cnt;
    for (int i = 0; i < MAX_NODES; i++) begin
      score_c.score[i] = (i < rec_q.node_cnt) ?
        SCORE_W'($signed(rec_q.coef[i])) - SCORE_W'(max_q) : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= ST_IDLE;
      scan_idx      <= '0;
      score_valid_o <= 1'b0;
      inflight      <= '0;
      done_o        <= 1'b0;
    end else begin
      score_valid_o <= 1'b0;
      // Records between the last row strobe and their pop
      inflight <= inflight + CREDIT_W'(last_issued_i) - CREDIT_W'(pop_o);
      case (state)
        ST_IDLE: begin
          if (pop_o) begin
            scan_idx <= '0;
            state    <= ST_SCAN;
          end
        end
        ST_SCAN: begin
          scan_idx <= scan_idx + 1'b1;
          if (scan_idx == SLOT_W'(MAX_NODES - 1)) begin
            state <= ST_EMIT;
          end
        end
        default: begin
          score_valid_o <= 1'b1;
          state         <= ST_IDLE;
        end
      endcase
      if (fetch_done_i && empty_i && (state == ST_IDLE) && (inflight == '0)
          && !last_issued_i) begin
        done_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      rec_q <= rec_i;
      max_q <= rec_i.coef[0];
    end else if ((state == ST_SCAN) && scan_hit) begin
      max_q <= rec_q.coef[scan_idx];
    end
    if (state == ST_EMIT) begin
      score_o <= score_c;
    end
  end

endmodule

/* project.f */
common/gat_pkg.sv
hw/gat_bram.sv
hw/coef_fifo.sv
dmvm/subgraph_fetch.sv
dmvm/attention_dot.sv
hw/score_shift.sv
hw/gat_top.sv
sim/gat_clk_gen.sv
sim/gat_tb.sv

/* sim/gat_clk_gen.sv */
`timescale 1ns/1ps

module gat_clk_gen (
  input  logic restart_i,
  output logic clk,
  output logic rst_n
);

  logic [3:0] rst_cnt = 4'd0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset held low for 10 rising edges after power up or a restart
  always @(posedge clk) begin
    if (restart_i) begin
      rst_cnt <= 4'd0;
    end else if (rst_cnt != 4'd10) begin
      rst_cnt <= rst_cnt + 4'd1;
    end
  end

  assign rst_n = (rst_cnt == 4'd10);

endmodule

/* sim/gat_tb.sv */
`timescale 1ns/1ps

module gat_tb;
  import gat_pkg::*;

  localparam int          MIXED_SG        = 10;
  localparam int          CHAIN_SG        = 12;
  localparam int          TOTAL_SG        = 2 + MIXED_SG + CHAIN_SG;
  localparam int          WATCHDOG_CYCLES = 200 * TOTAL_SG + 1000;
  localparam logic [31:0] LFSR_TAPS       = 32'h80200003;

  logic                  clk;
  logic                  rst_n;
  logic                  restart;
  logic                  quiet_chk;
  logic                  wh_we;
  logic [WH_ADDR_W-1:0]  wh_addr;
  wh_row_t               wh_data;
  logic                  wh_load_done;
  logic                  sg_we;
  logic [SG_ADDR_W-1:0]  sg_addr;
  sg_info_t              sg_data;
  logic                  sg_load_done;
  logic                  a_we;
  logic [FEAT_IDX_W-1:0] a_idx;
  data_t                 a_data;
  logic                  a_load_done;
  logic [SG_CNT_W-1:0]   num_sg;
  logic                  score_valid;
  score_rec_t            score_rec;
  logic                  done;
  logic                  done_prev;

  logic [31:0] lfsr = 32'h73fbb38a;
  wh_row_t     wh_mem [WH_DEPTH];
  sg_info_t    sg_mem [SG_DEPTH];
  data_t       a_vec [FEAT_NUM];
  score_rec_t  exp_q [$];

  gat_clk_gen clk_gen (.restart_i(restart), .clk(clk), .rst_n(rst_n));

  gat_top UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .wh_we_i        (wh_we),
    .wh_addr_i      (wh_addr),
    .wh_data_i      (wh_data),
    .wh_load_done_i (wh_load_done),
    .sg_we_i        (sg_we),
    .sg_addr_i      (sg_addr),
    .sg_data_i      (sg_data),
    .sg_load_done_i (sg_load_done),
    .a_we_i         (a_we),
    .a_idx_i        (a_idx),
    .a_data_i       (a_data),
    .a_load_done_i  (a_load_done),
    .num_sg_i       (num_sg),
    .score_valid_o  (score_valid),
    .score_o        (score_rec),
    .done_o         (done)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lsb  = lfsr[0];
      lfsr = (lfsr >> 1) ^ (lsb ? LFSR_TAPS : 32'h0);
      val  = {val[30:0], lsb};
    end
    return val;
  endfunction

  // Dot product, rescale with wrap, then LeakyReLU
  function automatic data_t model_coef(input int row);
    longint acc;
    data_t  w;
    acc = 0;
    for (int i = 0; i < FEAT_NUM; i++) begin
      acc = acc + longint'(a_vec[i]) * longint'($signed(wh_mem[row][i]));
    end
    acc = acc >>> FRAC_BITS;
    w = acc[DATA_W-1:0];
    if (w < 0) begin
      w = w >>> LEAKY_SHIFT;
    end
    return w;
  endfunction

  function automatic score_rec_t model_record(input int sg, input int first, input int cnt);
    score_rec_t r;
    data_t      c [MAX_NODES];
    data_t      mx;
    r = '0;
    r.sg_idx   = SG_ADDR_W'(sg);
    r.node_cnt = NODE_CNT_W'(cnt);
    for (int i = 0; i < cnt; i++) begin
      c[i] = model_coef(first + i);
    end
    mx = c[0];
    for (int i = 1; i < cnt; i++) begin
      if (c[i] > mx) begin
        mx = c[i];
      end
    end
    for (int i = 0; i < cnt; i++) begin
      r.score[i] = {c[i][DATA_W-1], c[i]} - {mx[DATA_W-1], mx};
    end
    return r;
  endfunction

  task automatic fill_table(input int nsg, input bit single, output int nrows);
    int cnt;
    nrows = 0;
    for (int s = 0; s < nsg; s++) begin
      if (single) begin
        cnt = 1;
      end else if (s < MAX_NODES) begin
        cnt = s + 1;
      end else if (s == 5 || s == nsg - 1) begin
        cnt = 0;
      end else begin
        cnt = rand_bits(2) + 1;
      end
      sg_mem[s] = '{first_row: WH_ADDR_W'(nrows), node_cnt: NODE_CNT_W'(cnt)};
      for (int r = nrows; r < nrows + cnt; r++) begin
        for (int i = 0; i < FEAT_NUM; i++) begin
          wh_mem[r][i] = rand_bits(DATA_W);
        end
      end
      nrows = nrows + cnt;
    end
    for (int i = 0; i < FEAT_NUM; i++) begin
      a_vec[i] = rand_bits(DATA_W);
    end
  endtask

  task automatic wait_reset_release();
    while (!rst_n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic restart_dut();
    restart      = 1'b1;
    wh_load_done = 1'b0;
    sg_load_done = 1'b0;
    a_load_done  = 1'b0;
    @(posedge clk);
    #1;
    restart = 1'b0;
    @(posedge clk);
    #1;
    quiet_chk = 1'b1;
    wait_reset_release();
  endtask

  // Load done levels rise one by one, start needs all three
  task automatic load_memories(input int nsg, input int nrows);
    num_sg = SG_CNT_W'(nsg);
    for (int r = 0; r < nrows; r++) begin
      wh_we   = 1'b1;
      wh_addr = WH_ADDR_W'(r);
      wh_data = wh_mem[r];
      @(posedge clk);
      #1;
    end
    wh_we        = 1'b0;
    wh_load_done = 1'b1;
    for (int s = 0; s < nsg; s++) begin
      sg_we   = 1'b1;
      sg_addr = SG_ADDR_W'(s);
      sg_data = sg_mem[s];
      @(posedge clk);
      #1;
    end
    sg_we        = 1'b0;
    sg_load_done = 1'b1;
    for (int i = 0; i < FEAT_NUM; i++) begin
      a_we   = 1'b1;
      a_idx  = FEAT_IDX_W'(i);
      a_data = a_vec[i];
      @(posedge clk);
      #1;
    end
    a_we        = 1'b0;
    a_load_done = 1'b1;
    quiet_chk   = 1'b0;
  endtask

  task automatic run_case(input int nsg, input int nrows);
    for (int s = 0; s < nsg; s++) begin
      if (sg_mem[s].node_cnt != '0) begin
        exp_q.push_back(model_record(s, sg_mem[s].first_row, sg_mem[s].node_cnt));
      end
    end
    load_memories(nsg, nrows);
    while (done !== 1'b1) begin
      @(negedge clk);
    end
    // Hold a while so the done checks see it stay high
    repeat (8) @(posedge clk);
    #1;
  endtask

  assert property (@(posedge clk) quiet_chk |-> !score_valid)
    else abort_run($sformatf("Mismatch score_valid_o before start: got %h expected 0",
                             $sampled(score_valid)));
  assert property (@(posedge clk) quiet_chk |-> !done)
    else abort_run($sformatf("Mismatch done_o before start: got %h expected 0",
                             $sampled(done)));
  assert property (@(posedge clk) disable iff (!rst_n) done |-> !score_valid)
    else abort_run("A record was emitted after done_o rose");
  assert property (@(posedge clk) disable iff (!rst_n) done |=> done)
    else abort_run("done_o fell without a reset");

  always @(negedge clk) begin : score_monitor
    score_rec_t want;
    if (rst_n && score_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("score_valid_o pulsed with no record expected");
      end else begin
        want = exp_q.pop_front();
        assert (score_rec.sg_idx == want.sg_idx)
          else abort_run($sformatf("Mismatch score_o.sg_idx: got %h expected %h",
                                   score_rec.sg_idx, want.sg_idx));
        assert (score_rec.node_cnt == want.node_cnt)
          else abort_run($sformatf("Mismatch score_o.node_cnt: got %h expected %h",
                                   score_rec.node_cnt, want.node_cnt));
        for (int i = 0; i < MAX_NODES; i++) begin
          assert (score_rec.score[i] == want.score[i])
            else abort_run($sformatf("Mismatch score_o.score[%0d]: got %h expected %h",
                                     i, score_rec.score[i], want.score[i]));
        end
      end
    end
    if (rst_n && done && !done_prev) begin
      assert (exp_q.size() == 0)
        else abort_run($sformatf("done_o rose with %0d records still expected", exp_q.size()));
    end
    done_prev = rst_n && done;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("Timeout after %0d cycles with the tests unfinished", WATCHDOG_CYCLES));
  end

  initial begin : stimulus
    int nrows;
    restart      = 1'b0;
    quiet_chk    = 1'b0;
    done_prev    = 1'b0;
    wh_we        = 1'b0;
    wh_addr      = '0;
    wh_data      = '0;
    wh_load_done = 1'b0;
    sg_we        = 1'b0;
    sg_addr      = '0;
    sg_data      = '0;
    sg_load_done = 1'b0;
    a_we         = 1'b0;
    a_idx        = '0;
    a_data       = '0;
    a_load_done  = 1'b0;
    num_sg       = '0;
    @(posedge clk);
    #1;
    quiet_chk = 1'b1;
    wait_reset_release();

    // One full subgraph with positive features and a
    sg_mem[0] = '{first_row: '0, node_cnt: NODE_CNT_W'(MAX_NODES)};
    for (int r = 0; r < MAX_NODES; r++) begin
      for (int i = 0; i < FEAT_NUM; i++) begin
        wh_mem[r][i] = rand_bits(9) + 1;
      end
    end
    for (int i = 0; i < FEAT_NUM; i++) begin
      a_vec[i] = rand_bits(8) + 1;
    end
    run_case(1, MAX_NODES);
    restart_dut();

    // Same rows, a flipped so every dot product goes negative
    for (int i = 0; i < FEAT_NUM; i++) begin
      a_vec[i] = -a_vec[i];
    end
    run_case(1, MAX_NODES);
    restart_dut();

    fill_table(MIXED_SG, 1'b0, nrows);
    run_case(MIXED_SG, nrows);
    restart_dut();

    // Single node subgraphs drain the credits
    fill_table(CHAIN_SG, 1'b1, nrows);
    run_case(CHAIN_SG, nrows);

    if (exp_q.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run($sformatf("%0d expected records were never emitted", exp_q.size()));
    end
  end

endmodule
